// File: rtl/pkt_rf_pkg.sv
// shared widths, word indices, command bits and helpers for the packet register file
package pkt_rf_pkg;

  // ----------------------------------------
  // widths and types
  // ----------------------------------------
  localparam int WORD_W    = 32;
  localparam int NUM_WORDS = 32;

  typedef logic [WORD_W-1:0]           word_t;
  typedef logic [5:0]                  reg_addr_t;
  // word 0 sits in the top bits of a nic line
  typedef logic [511:0]                line_t;
  typedef logic [31:0]                 nic_addr_t;
  // word 0 sits in the low bits of a bank vector
  typedef logic [NUM_WORDS*WORD_W-1:0] bank_vec_t;

  // one operation per cycle on the packet bank, highest priority first:
  // replace, recv, send-clear, then plain writes
  typedef enum logic [1:0] {
    BANK_OP_WRITE,
    BANK_OP_REPLACE,
    BANK_OP_RECV,
    BANK_OP_SEND_CLR
  } bank_op_t;

  // ----------------------------------------
  // packet bank word map
  // ----------------------------------------
  localparam int STATUS_IDX = 31;
  localparam int CTRL_IDX   = 30;
  localparam int RADDR_IDX  = 29;
  localparam int WADDR_IDX  = 28;
  // words 20..27 are scratch, 16..19 descriptor, 0..15 packet data
  localparam int DESC_BASE  = 16;
  localparam int DATA_WORDS = 16;
  localparam int DESC_WORDS = 4;

  // command word bits
  localparam int TO_READ_BIT    = 31;
  localparam int TO_WRITE_BIT   = 30;
  localparam int TO_RECV_BIT    = 29;
  localparam int TO_SEND_BIT    = 28;
  localparam int TO_REPLACE_BIT = 27;
  localparam int PKT_VALID_BIT  = 0;

  // buffer id field of a descriptor beat, in units of 32-word buffers
  localparam int BUF_ID_MSB = 123;
  localparam int BUF_ID_W   = 4;

  // pick one word out of a packed bank
  function automatic word_t word_of(bank_vec_t vec, int unsigned idx);
    return vec[idx*WORD_W +: WORD_W];
  endfunction

  // pick one word out of a nic line, word 0 at the top
  function automatic word_t line_word(line_t line, int unsigned idx);
    return line[(DATA_WORDS-1-idx)*WORD_W +: WORD_W];
  endfunction

endpackage

// File: rtl/gpr_file.sv
// general-purpose registers with three read ports shared across both banks
`timescale 1ns/1ps

module gpr_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pkt_rf_pkg::reg_addr_t raddr_a_i,
  input  pkt_rf_pkg::reg_addr_t raddr_b_i,
  input  pkt_rf_pkg::reg_addr_t raddr_c_i,
  input  pkt_rf_pkg::reg_addr_t waddr_a_i,
  input  pkt_rf_pkg::reg_addr_t waddr_b_i,
  input  pkt_rf_pkg::word_t     wdata_a_i,
  input  pkt_rf_pkg::word_t     wdata_b_i,
  input  logic                  we_a_i,
  input  logic                  we_b_i,
  input  pkt_rf_pkg::bank_vec_t bank_i,
  output pkt_rf_pkg::word_t     rdata_a_o,
  output pkt_rf_pkg::word_t     rdata_b_o,
  output pkt_rf_pkg::word_t     rdata_c_o
);
  import pkt_rf_pkg::*;

  word_t mem [NUM_WORDS];

  // ----------------------------------------
  // read muxes, bit 5 picks the packet bank
  // ----------------------------------------
  assign rdata_a_o = raddr_a_i[5] ? word_of(bank_i, raddr_a_i[4:0]) : mem[raddr_a_i[4:0]];
  assign rdata_b_o = raddr_b_i[5] ? word_of(bank_i, raddr_b_i[4:0]) : mem[raddr_b_i[4:0]];
  assign rdata_c_o = raddr_c_i[5] ? word_of(bank_i, raddr_c_i[4:0]) : mem[raddr_c_i[4:0]];

  // ----------------------------------------
  // write ports
  // ----------------------------------------
  // address compare includes bit 5, so bank writes never hit here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // x0 is hardwired
      mem[0] <= '0;
      for (int i = 1; i < NUM_WORDS; i++) begin
        // port b wins on a shared address
        if (we_b_i && waddr_b_i == reg_addr_t'(i)) begin
          mem[i] <= wdata_b_i;
        end else if (we_a_i && waddr_a_i == reg_addr_t'(i)) begin
          mem[i] <= wdata_a_i;
        end
      end
    end
  end

endmodule

// File: rtl/pkt_bank.sv
// packet register bank with cpu write ports, bulk loads from the nic buffers and status word
`timescale 1ns/1ps

module pkt_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pkt_rf_pkg::reg_addr_t waddr_a_i,
  input  pkt_rf_pkg::reg_addr_t waddr_b_i,
  input  pkt_rf_pkg::word_t     wdata_a_i,
  input  pkt_rf_pkg::word_t     wdata_b_i,
  input  logic                  we_a_i,
  input  logic                  we_b_i,
  input  pkt_rf_pkg::bank_op_t  bank_op_i,
  input  pkt_rf_pkg::line_t     stage_line_i,
  input  pkt_rf_pkg::bank_vec_t recv_vec_i,
  input  pkt_rf_pkg::word_t     status_i,
  output pkt_rf_pkg::bank_vec_t bank_o
);
  import pkt_rf_pkg::*;

  // words 0..30, word 31 is held apart in status_q
  word_t bank [STATUS_IDX];
  word_t status_q;

  // ----------------------------------------
  // bank update, one operation per cycle
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < STATUS_IDX; i++) begin
        bank[i] <= '0;
      end
    end else begin
      case (bank_op_i)
        BANK_OP_REPLACE: begin
          // staged line into the data words, then step both nic addresses
          for (int i = 0; i < DATA_WORDS; i++) begin
            bank[i] <= line_word(stage_line_i, i);
          end
          bank[RADDR_IDX] <= bank[RADDR_IDX] + 32'd1;
          bank[WADDR_IDX] <= bank[WADDR_IDX] + 32'd1;
          bank[CTRL_IDX]  <= '0;
        end
        BANK_OP_RECV: begin
          // data, descriptor, addresses and valid flag of the received packet
          for (int i = 0; i < DESC_BASE + DESC_WORDS; i++) begin
            bank[i] <= word_of(recv_vec_i, i);
          end
          bank[RADDR_IDX] <= word_of(recv_vec_i, RADDR_IDX);
          bank[WADDR_IDX] <= word_of(recv_vec_i, WADDR_IDX);
          bank[CTRL_IDX]  <= word_of(recv_vec_i, CTRL_IDX);
        end
        BANK_OP_SEND_CLR: begin
          bank[CTRL_IDX] <= '0;
        end
        default: begin
          // cpu writes with bit 5 set, port b first
          for (int i = 0; i < STATUS_IDX; i++) begin
            if (we_b_i && waddr_b_i == reg_addr_t'(NUM_WORDS + i)) begin
              bank[i] <= wdata_b_i;
            end else if (we_a_i && waddr_a_i == reg_addr_t'(NUM_WORDS + i)) begin
              bank[i] <= wdata_a_i;
            end
          end
        end
      endcase
    end
  end

  // status word tracks the input a cycle late, cpu writes are dropped
  always_ff @(posedge clk) begin
    status_q <= status_i;
  end

  // pack for the read muxes and the nic side
  always_comb begin
    for (int i = 0; i < STATUS_IDX; i++) begin
      bank_o[i*WORD_W +: WORD_W] = bank[i];
    end
    bank_o[STATUS_IDX*WORD_W +: WORD_W] = status_q;
  end

endmodule

// File: rtl/dra_controller.sv
// direct register access controller, turns command bits into nic request pulses and bank ops
`timescale 1ns/1ps

module dra_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pkt_rf_pkg::bank_vec_t bank_i,
  input  logic                  reg_rvalid_desp_i,
  output pkt_rf_pkg::bank_op_t  bank_op_o,
  output logic                  reg_rd_o,
  output pkt_rf_pkg::nic_addr_t reg_raddr_o,
  output logic                  reg_wr_o,
  output logic                  reg_wr_desp_o,
  output pkt_rf_pkg::nic_addr_t reg_waddr_o,
  output logic                  tx_beat_en_o,
  output logic                  tx_desc_beat_o,
  output logic                  rx_desc_beat_o
);
  import pkt_rf_pkg::*;

  word_t cmd;
  logic  pre_read, pre_write, pre_recv, pre_send;
  logic  rd_rise, wr_rise, recv_rise, send_rise;
  // 0 = data beat next, 1 = descriptor beat next
  logic  tx_beat_q;
  // second beat of an incoming packet
  logic  rx_beat_q;

  assign cmd       = word_of(bank_i, CTRL_IDX);
  assign rd_rise   = cmd[TO_READ_BIT] & ~pre_read;
  assign wr_rise   = cmd[TO_WRITE_BIT] & ~pre_write;
  assign recv_rise = cmd[TO_RECV_BIT] & ~pre_recv;
  assign send_rise = cmd[TO_SEND_BIT] & ~pre_send;

  // a beat goes out next cycle on a new write/send or the pending descriptor
  assign tx_beat_en_o   = wr_rise | send_rise | tx_beat_q;
  assign tx_desc_beat_o = tx_beat_q;
  assign rx_desc_beat_o = rx_beat_q;

  // ----------------------------------------
  // bank operation decode
  // ----------------------------------------
  always_comb begin
    if (cmd[TO_REPLACE_BIT]) begin
      bank_op_o = BANK_OP_REPLACE;
    end else if (recv_rise) begin
      bank_op_o = BANK_OP_RECV;
    end else if (cmd[TO_SEND_BIT]) begin
      bank_op_o = BANK_OP_SEND_CLR;
    end else begin
      bank_op_o = BANK_OP_WRITE;
    end
  end

  // ----------------------------------------
  // edge detect and request pulses
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {pre_read, pre_write, pre_recv, pre_send} <= '0;
      tx_beat_q     <= 1'b0;
      rx_beat_q     <= 1'b0;
      reg_rd_o      <= 1'b0;
      reg_raddr_o   <= '0;
      reg_wr_o      <= 1'b0;
      reg_wr_desp_o <= 1'b0;
      reg_waddr_o   <= '0;
    end else begin
      {pre_read, pre_write, pre_recv, pre_send} <= cmd[TO_READ_BIT:TO_SEND_BIT];
      reg_rd_o <= rd_rise;
      if (rd_rise) begin
        reg_raddr_o <= word_of(bank_i, RADDR_IDX);
      end
      reg_wr_o      <= tx_beat_en_o & ~tx_beat_q;
      reg_wr_desp_o <= tx_beat_en_o & tx_beat_q;
      if (tx_beat_en_o) begin
        // a write command keeps the toggle on the data beat
        tx_beat_q   <= cmd[TO_WRITE_BIT] ? 1'b0 : ~tx_beat_q;
        reg_waddr_o <= word_of(bank_i, WADDR_IDX);
      end
      // restarts whenever the nic drops its valid
      rx_beat_q <= reg_rvalid_desp_i & ~rx_beat_q;
    end
  end

endmodule

// File: rtl/nic_rx_buffers.sv
// read staging line and receive packet buffer fed from the nic response bus
`timescale 1ns/1ps

module nic_rx_buffers (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pkt_rf_pkg::line_t     reg_rdata_i,
  input  logic                  reg_rvalid_i,
  input  logic                  reg_rvalid_desp_i,
  input  logic                  rx_desc_beat_i,
  input  pkt_rf_pkg::bank_op_t  bank_op_i,
  output pkt_rf_pkg::line_t     stage_line_o,
  output pkt_rf_pkg::bank_vec_t recv_vec_o,
  output pkt_rf_pkg::word_t     status_o
);
  import pkt_rf_pkg::*;

  line_t               rx_data;
  word_t               rx_desc [DESC_WORDS];
  nic_addr_t           rx_raddr;
  nic_addr_t           rx_waddr;
  logic                pkt_valid;
  logic                desc_beat;
  logic [BUF_ID_W-1:0] buf_id;

  assign desc_beat = reg_rvalid_desp_i & rx_desc_beat_i;
  assign buf_id    = reg_rdata_i[BUF_ID_MSB -: BUF_ID_W];

  // ----------------------------------------
  // line capture
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reg_rvalid_i) begin
      stage_line_o <= reg_rdata_i;
    end
    // first beat of a packet is the data line
    if (reg_rvalid_desp_i && !rx_desc_beat_i) begin
      rx_data <= reg_rdata_i;
    end
    // descriptor sits in the low 128 bits, word 16 on top
    if (desc_beat) begin
      for (int j = 0; j < DESC_WORDS; j++) begin
        rx_desc[j] <= line_word(reg_rdata_i, DATA_WORDS - DESC_WORDS + j);
      end
    end
  end

  // ----------------------------------------
  // packet valid and derived addresses
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_valid <= 1'b0;
      rx_raddr  <= '0;
      rx_waddr  <= '0;
    end else if (desc_beat) begin
      pkt_valid <= 1'b1;
      // payload starts one line past the descriptor slot of the buffer
      rx_raddr  <= nic_addr_t'(buf_id) * NUM_WORDS + 1;
      rx_waddr  <= nic_addr_t'(buf_id) * NUM_WORDS;
    end else if (bank_op_i == BANK_OP_RECV) begin
      pkt_valid <= 1'b0;
    end
  end

  always_comb begin
    status_o                = '0;
    status_o[PKT_VALID_BIT] = pkt_valid;
  end

  // bank image for the recv operation, unused words stay zero
  always_comb begin
    recv_vec_o = '0;
    for (int i = 0; i < DATA_WORDS; i++) begin
      recv_vec_o[i*WORD_W +: WORD_W] = line_word(rx_data, i);
    end
    for (int j = 0; j < DESC_WORDS; j++) begin
      recv_vec_o[(DESC_BASE+j)*WORD_W +: WORD_W] = rx_desc[j];
    end
    recv_vec_o[WADDR_IDX*WORD_W +: WORD_W] = rx_waddr;
    recv_vec_o[RADDR_IDX*WORD_W +: WORD_W] = rx_raddr;
    recv_vec_o[CTRL_IDX*WORD_W +: WORD_W]  = status_o;
  end

endmodule

// File: rtl/nic_tx_formatter.sv
// builds the 512-bit nic write line for data beats and descriptor beats
`timescale 1ns/1ps

module nic_tx_formatter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pkt_rf_pkg::bank_vec_t bank_i,
  input  logic                  beat_en_i,
  input  logic                  tx_desc_beat_i,
  output pkt_rf_pkg::line_t     reg_wdata_o
);
  import pkt_rf_pkg::*;

  word_t desc_snap [DESC_WORDS];
  line_t data_line;
  line_t desc_line;

  // data words in line order, word 0 on top
  always_comb begin
    for (int i = 0; i < DATA_WORDS; i++) begin
      data_line[(DATA_WORDS-1-i)*WORD_W +: WORD_W] = word_of(bank_i, i);
    end
  end

  // descriptor in the low 128 bits, zeros above
  always_comb begin
    desc_line = '0;
    for (int j = 0; j < DESC_WORDS; j++) begin
      desc_line[(DESC_WORDS-1-j)*WORD_W +: WORD_W] = desc_snap[j];
    end
  end

  // descriptor is frozen with the data beat so cpu writes cannot tear it
  always_ff @(posedge clk) begin
    if (beat_en_i && !tx_desc_beat_i) begin
      for (int j = 0; j < DESC_WORDS; j++) begin
        desc_snap[j] <= word_of(bank_i, DESC_BASE + j);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_wdata_o <= '0;
    end else if (beat_en_i) begin
      reg_wdata_o <= tx_desc_beat_i ? desc_line : data_line;
    end
  end

endmodule

// File: rtl/pkt_regfile_top.sv
// register file top with packet bank and nic direct register access
`timescale 1ns/1ps

module pkt_regfile_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // read ports
  input  pkt_rf_pkg::reg_addr_t raddr_a_i,
  output pkt_rf_pkg::word_t     rdata_a_o,
  input  pkt_rf_pkg::reg_addr_t raddr_b_i,
  output pkt_rf_pkg::word_t     rdata_b_o,
  input  pkt_rf_pkg::reg_addr_t raddr_c_i,
  output pkt_rf_pkg::word_t     rdata_c_o,
  // write ports
  input  pkt_rf_pkg::reg_addr_t waddr_a_i,
  input  pkt_rf_pkg::word_t     wdata_a_i,
  input  logic                  we_a_i,
  input  pkt_rf_pkg::reg_addr_t waddr_b_i,
  input  pkt_rf_pkg::word_t     wdata_b_i,
  input  logic                  we_b_i,
  // nic side
  output logic                  reg_rd_o,
  output pkt_rf_pkg::nic_addr_t reg_raddr_o,
  input  pkt_rf_pkg::line_t     reg_rdata_i,
  input  logic                  reg_rvalid_i,
  input  logic                  reg_rvalid_desp_i,
  output logic                  reg_wr_o,
  output logic                  reg_wr_desp_o,
  output pkt_rf_pkg::nic_addr_t reg_waddr_o,
  output pkt_rf_pkg::line_t     reg_wdata_o,
  input  pkt_rf_pkg::word_t     status_i,
  output pkt_rf_pkg::word_t     status_o
);
  import pkt_rf_pkg::*;

  bank_vec_t bank_vec;
  bank_vec_t recv_vec;
  bank_op_t  bank_op;
  line_t     stage_line;
  logic      tx_beat_en;
  logic      tx_desc_beat;
  logic      rx_desc_beat;

  gpr_file u_gpr_file (
    .clk, .rst_n,
    .raddr_a_i, .raddr_b_i, .raddr_c_i,
    .waddr_a_i, .waddr_b_i, .wdata_a_i, .wdata_b_i, .we_a_i, .we_b_i,
    .bank_i    (bank_vec),
    .rdata_a_o, .rdata_b_o, .rdata_c_o
  );

  pkt_bank u_pkt_bank (
    .clk, .rst_n,
    .waddr_a_i, .waddr_b_i, .wdata_a_i, .wdata_b_i, .we_a_i, .we_b_i,
    .bank_op_i    (bank_op),
    .stage_line_i (stage_line),
    .recv_vec_i   (recv_vec),
    .status_i,
    .bank_o       (bank_vec)
  );

  dra_controller u_dra_controller (
    .clk, .rst_n,
    .bank_i         (bank_vec),
    .reg_rvalid_desp_i,
    .bank_op_o      (bank_op),
    .reg_rd_o, .reg_raddr_o, .reg_wr_o, .reg_wr_desp_o, .reg_waddr_o,
    .tx_beat_en_o   (tx_beat_en),
    .tx_desc_beat_o (tx_desc_beat),
    .rx_desc_beat_o (rx_desc_beat)
  );

  nic_rx_buffers u_nic_rx_buffers (
    .clk, .rst_n,
    .reg_rdata_i, .reg_rvalid_i, .reg_rvalid_desp_i,
    .rx_desc_beat_i (rx_desc_beat),
    .bank_op_i      (bank_op),
    .stage_line_o   (stage_line),
    .recv_vec_o     (recv_vec),
    .status_o
  );

  nic_tx_formatter u_nic_tx_formatter (
    .clk, .rst_n,
    .bank_i         (bank_vec),
    .beat_en_i      (tx_beat_en),
    .tx_desc_beat_i (tx_desc_beat),
    .reg_wdata_o
  );

endmodule

// File: verif/tb_pkt_regfile_assert.sv
// concurrent checks on the nic request pulses and the zero register, bound into the top level
`timescale 1ns/1ps

module tb_pkt_regfile_assert (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  rd_pulse_i,
  input logic                  wr_pulse_i,
  input logic                  desp_pulse_i,
  input pkt_rf_pkg::word_t     cmd_i,
  input pkt_rf_pkg::reg_addr_t raddr_i,
  input pkt_rf_pkg::word_t     rdata_i
);
  import pkt_rf_pkg::*;

  // request pulses last one cycle
  rd_single: assert property (@(posedge clk) disable iff (!rst_n) rd_pulse_i |=> !rd_pulse_i)
    else $error("reg_rd_o held for more than one cycle");
  wr_single: assert property (@(posedge clk) disable iff (!rst_n) wr_pulse_i |=> !wr_pulse_i)
    else $error("reg_wr_o held for more than one cycle");

  // descriptor beat comes right after the data beat of a send
  desp_after_send: assert property (@(posedge clk) disable iff (!rst_n)
    desp_pulse_i |-> $past(wr_pulse_i) && $past(cmd_i[TO_SEND_BIT], 2))
    else $error("descriptor beat without a preceding send data beat");
  no_desp_on_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_pulse_i && !$past(cmd_i[TO_SEND_BIT]) |=> !desp_pulse_i)
    else $error("descriptor beat after a plain write beat");

  // x0 reads zero
  zero_reg: assert property (@(posedge clk) disable iff (!rst_n) raddr_i == '0 |-> rdata_i == '0)
    else $error("register 0 read back a nonzero value");

endmodule

bind pkt_regfile_top tb_pkt_regfile_assert u_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .rd_pulse_i   (reg_rd_o),
  .wr_pulse_i   (reg_wr_o),
  .desp_pulse_i (reg_wr_desp_o),
  .cmd_i        (bank_vec[pkt_rf_pkg::CTRL_IDX*32 +: 32]),
  .raddr_i      (raddr_a_i),
  .rdata_i      (rdata_a_o)
);

// File: verif/tb_pkt_regfile.sv
// table-driven testbench for the packet register file top built with the project file list
`timescale 1ns/1ps

module tb_pkt_regfile;
  import pkt_rf_pkg::*;

  typedef enum logic [3:0] {
    OP_WRA, OP_WRAB, OP_RD, OP_STATUS, OP_FILL, OP_EXP_WR,
    OP_EXP_SEND, OP_BANK, OP_PKT, OP_CHK_STATUS, OP_EXP_RD
  } op_e;

  // one stimulus step with the expected read value in exp where the op has one
  typedef struct packed {
    op_e       op;
    reg_addr_t addr;
    word_t     data;
    word_t     exp;
  } row_t;

  localparam int        NROWS    = 28;
  localparam reg_addr_t CMD_ADDR = 6'd62;

  logic      clk, rst_n;
  reg_addr_t raddr_a_i, raddr_b_i, raddr_c_i, waddr_a_i, waddr_b_i;
  word_t     wdata_a_i, wdata_b_i, rdata_a_o, rdata_b_o, rdata_c_o, status_i, status_o;
  logic      we_a_i, we_b_i, reg_rvalid_i, reg_rvalid_desp_i;
  logic      reg_rd_o, reg_wr_o, reg_wr_desp_o;
  nic_addr_t reg_raddr_o, reg_waddr_o;
  line_t     reg_rdata_i, reg_wdata_o;

  // shadow of the packet bank and of the nic side buffers
  word_t       model [NUM_WORDS];
  word_t       rx_model [DESC_BASE + DESC_WORDS];
  nic_addr_t   rx_base;
  line_t       stage_model;
  line_t       exp_line;
  int unsigned seed;

  row_t rows [NROWS] = '{
    // general-purpose registers, x0 and port b priority
    '{OP_WRA,        6'd5,  32'h1234_5678, 32'h0},
    '{OP_RD,         6'd5,  32'h0,         32'h1234_5678},
    '{OP_WRA,        6'd0,  32'hdead_beef, 32'h0},
    '{OP_RD,         6'd0,  32'h0,         32'h0},
    '{OP_WRAB,       6'd7,  32'haaaa_0001, 32'hbbbb_0002},
    '{OP_RD,         6'd7,  32'h0,         32'hbbbb_0002},
    // bank scratch word and the delayed status word that ignores writes
    '{OP_WRA,        6'd52, 32'hcafe_f00d, 32'h0},
    '{OP_RD,         6'd52, 32'h0,         32'hcafe_f00d},
    '{OP_STATUS,     6'd63, 32'h5a5a_0003, 32'h0},
    '{OP_WRA,        6'd63, 32'hffff_ffff, 32'h0},
    '{OP_RD,         6'd63, 32'h0,         32'h5a5a_0003},
    // random payload, nic addresses, write command, send command
    '{OP_FILL,       6'd0,  32'h0,         32'h0},
    '{OP_WRA,        6'd60, 32'h0000_0100, 32'h0},
    '{OP_WRA,        6'd61, 32'h0000_0200, 32'h0},
    '{OP_WRA,        6'd62, 32'h4000_0000, 32'h0},
    '{OP_EXP_WR,     6'd0,  32'h0,         32'h0},
    '{OP_WRA,        6'd62, 32'h1000_0000, 32'h0},
    '{OP_EXP_SEND,   6'd0,  32'h0,         32'h0},
    '{OP_BANK,       6'd0,  32'h0,         32'h0},
    // two-beat packet and the receive command
    '{OP_PKT,        6'd0,  32'h0,         32'h0},
    '{OP_CHK_STATUS, 6'd0,  32'h0,         32'h1},
    '{OP_WRA,        6'd62, 32'h2000_0000, 32'h0},
    '{OP_BANK,       6'd0,  32'h0,         32'h0},
    '{OP_CHK_STATUS, 6'd0,  32'h0,         32'h0},
    // read request, response line, replace
    '{OP_WRA,        6'd62, 32'h8000_0000, 32'h0},
    '{OP_EXP_RD,     6'd0,  32'h0,         32'h0},
    '{OP_WRA,        6'd62, 32'h0800_0000, 32'h0},
    '{OP_BANK,       6'd0,  32'h0,         32'h0}
  };

  pkt_regfile_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // about 20 cycles of budget per table row
  initial begin
    repeat (NROWS * 20) @(posedge clk);
    fail_run("watchdog expired before the table was done");
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input nic_addr_t got, input nic_addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // expected values
  // ----------------------------------------
  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < DATA_WORDS; i++) begin
      l[i*WORD_W +: WORD_W] = $urandom;
    end
    return l;
  endfunction

  // shadow words 0..15 as a nic line with word 0 in the top bits
  function automatic line_t model_line();
    line_t l;
    for (int i = 0; i < DATA_WORDS; i++) begin
      l[(DATA_WORDS-1-i)*WORD_W +: WORD_W] = model[i];
    end
    return l;
  endfunction

  // bank side effects of a command word once it has landed
  task automatic apply_cmd(input word_t cmd);
    if (cmd[TO_REPLACE_BIT]) begin
      for (int i = 0; i < DATA_WORDS; i++) begin
        model[i] = stage_model[(DATA_WORDS-1-i)*WORD_W +: WORD_W];
      end
      model[RADDR_IDX] = model[RADDR_IDX] + 1;
      model[WADDR_IDX] = model[WADDR_IDX] + 1;
      model[CTRL_IDX]  = '0;
    end else if (cmd[TO_RECV_BIT]) begin
      for (int i = 0; i < DESC_BASE + DESC_WORDS; i++) begin
        model[i] = rx_model[i];
      end
      model[RADDR_IDX] = rx_base + 1;
      model[WADDR_IDX] = rx_base;
      // command word picks up the packet-valid flag
      model[CTRL_IDX]  = 32'h1;
    end else if (cmd[TO_SEND_BIT]) begin
      model[CTRL_IDX] = '0;
    end
  endtask

  // ----------------------------------------
  // drivers
  // ----------------------------------------
  task automatic write_a(input reg_addr_t addr, input word_t data);
    @(posedge clk);
    waddr_a_i <= addr;
    wdata_a_i <= data;
    we_a_i    <= 1'b1;
    @(posedge clk);
    we_a_i <= 1'b0;
    if (addr[5] && addr[4:0] != STATUS_IDX) begin
      model[addr[4:0]] = data;
    end
    if (addr == CMD_ADDR) begin
      apply_cmd(data);
    end
  endtask

  task automatic read_check(input reg_addr_t addr, input word_t exp);
    @(posedge clk);
    raddr_a_i <= addr;
    raddr_b_i <= addr;
    raddr_c_i <= addr;
    @(negedge clk);
    check_word("rdata_a_o", rdata_a_o, exp);
    check_word("rdata_b_o", rdata_b_o, exp);
    check_word("rdata_c_o", rdata_c_o, exp);
  endtask

  // words 0..19 get random data at one word per cycle
  task automatic fill_bank();
    for (int i = 0; i < DESC_BASE + DESC_WORDS; i++) begin
      @(posedge clk);
      model[i]   = $urandom;
      waddr_a_i <= reg_addr_t'(NUM_WORDS + i);
      wdata_a_i <= model[i];
      we_a_i    <= 1'b1;
    end
    @(posedge clk);
    we_a_i <= 1'b0;
  endtask

  // bounded wait for a request pulse sampled on falling edges
  task automatic wait_pulse(input bit want_rd);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 16) begin
        fail_run("no request pulse from the DUT within 16 cycles");
      end
    end while (!(want_rd ? reg_rd_o : reg_wr_o));
  endtask

  task automatic expect_write();
    wait_pulse(1'b0);
    check_addr("reg_waddr_o", reg_waddr_o, model[WADDR_IDX]);
    check_line("reg_wdata_o", reg_wdata_o, model_line());
    // exactly one beat and no descriptor after a plain write
    repeat (3) begin
      @(negedge clk);
      check_flag("reg_wr_o", reg_wr_o, 1'b0);
      check_flag("reg_wr_desp_o", reg_wr_desp_o, 1'b0);
    end
  endtask

  task automatic expect_send();
    wait_pulse(1'b0);
    check_flag("reg_wr_desp_o", reg_wr_desp_o, 1'b0);
    check_line("reg_wdata_o", reg_wdata_o, model_line());
    // descriptor in the low 128 bits with word 16 on top
    exp_line = '0;
    for (int j = 0; j < DESC_WORDS; j++) begin
      exp_line[(DESC_WORDS-1-j)*WORD_W +: WORD_W] = model[DESC_BASE + j];
    end
    @(negedge clk);
    check_flag("reg_wr_o", reg_wr_o, 1'b0);
    check_flag("reg_wr_desp_o", reg_wr_desp_o, 1'b1);
    check_line("reg_wdata_o", reg_wdata_o, exp_line);
  endtask

  task automatic send_packet();
    line_t data_beat;
    data_beat = rand_line();
    exp_line  = '0;
    for (int j = 0; j < DESC_WORDS; j++) begin
      exp_line[(DESC_WORDS-1-j)*WORD_W +: WORD_W] = $urandom;
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      rx_model[i] = data_beat[(DATA_WORDS-1-i)*WORD_W +: WORD_W];
    end
    for (int j = 0; j < DESC_WORDS; j++) begin
      rx_model[DESC_BASE + j] = exp_line[(DESC_WORDS-1-j)*WORD_W +: WORD_W];
    end
    // one 32-word nic buffer per buffer id
    rx_base = nic_addr_t'(exp_line[BUF_ID_MSB -: BUF_ID_W]) * 32;
    @(posedge clk);
    reg_rvalid_desp_i <= 1'b1;
    reg_rdata_i       <= data_beat;
    @(posedge clk);
    reg_rdata_i <= exp_line;
    @(posedge clk);
    reg_rvalid_desp_i <= 1'b0;
  endtask

  task automatic expect_read();
    wait_pulse(1'b1);
    check_addr("reg_raddr_o", reg_raddr_o, model[RADDR_IDX]);
    stage_model = rand_line();
    @(posedge clk);
    reg_rvalid_i <= 1'b1;
    reg_rdata_i  <= stage_model;
    @(posedge clk);
    reg_rvalid_i <= 1'b0;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    row_t row;
    seed = $urandom(32'h9a07acb2);
    rst_n = 1'b0;
    {raddr_a_i, raddr_b_i, raddr_c_i, waddr_a_i, waddr_b_i} = '0;
    {wdata_a_i, wdata_b_i, status_i} = '0;
    {we_a_i, we_b_i, reg_rvalid_i, reg_rvalid_desp_i} = '0;
    reg_rdata_i = '0;
    stage_model = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      row = rows[r];
      case (row.op)
        OP_WRA:  write_a(row.addr, row.data);
        OP_RD:   read_check(row.addr, row.exp);
        OP_WRAB: begin
          @(posedge clk);
          waddr_a_i <= row.addr;
          wdata_a_i <= row.data;
          we_a_i    <= 1'b1;
          waddr_b_i <= row.addr;
          wdata_b_i <= row.exp;
          we_b_i    <= 1'b1;
          @(posedge clk);
          we_a_i <= 1'b0;
          we_b_i <= 1'b0;
        end
        OP_STATUS: begin
          // word 31 still shows the old status in the cycle the input changes
          @(posedge clk);
          status_i  <= row.data;
          raddr_a_i <= row.addr;
          @(negedge clk);
          check_word("rdata_a_o", rdata_a_o, row.exp);
        end
        OP_FILL:     fill_bank();
        OP_EXP_WR:   expect_write();
        OP_EXP_SEND: expect_send();
        OP_PKT:      send_packet();
        OP_EXP_RD:   expect_read();
        OP_CHK_STATUS: begin
          @(negedge clk);
          check_word("status_o", status_o, row.exp);
        end
        OP_BANK: begin
          // words 0..30 against the shadow without the status word
          for (int i = 0; i < STATUS_IDX; i++) begin
            read_check(reg_addr_t'(NUM_WORDS + i), model[i]);
          end
        end
        default: fail_run("unknown operation in the stimulus table");
      endcase
    end
    repeat (2) @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: project.f
rtl/pkt_rf_pkg.sv
rtl/gpr_file.sv
rtl/pkt_bank.sv
rtl/dra_controller.sv
rtl/nic_rx_buffers.sv
rtl/nic_tx_formatter.sv
rtl/pkt_regfile_top.sv
verif/tb_pkt_regfile_assert.sv
verif/tb_pkt_regfile.sv
